//--- Makefile
# Verilator build and run of the precise exception testbench.

VERILATOR ?= verilator
TOP       ?= tb_precise_exc
SEED      ?= 98182
OBJ_DIR   ?= obj_dir
ERR_LIMIT ?= 1000
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR=$(VERILATOR) TOP=$(TOP) SEED=$(SEED) OBJ_DIR=$(OBJ_DIR)"

test:
	$(VERILATOR) --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-GSEED=$(SEED) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- source/exc_capture.sv
// Exception capture registers for mepc, mcause and mtval.

`timescale 1ns/1ns

module exc_capture (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               exc_i,
	input  hf_pkg::xlen_t      exc_pc_i,
	input  hf_pkg::exc_cause_e exc_cause_i,
	input  hf_pkg::xlen_t      exc_tval_i,
	output hf_pkg::xlen_t      mepc_o,
	output hf_pkg::xlen_t      mcause_o,
	output hf_pkg::xlen_t      mtval_o
);

	hf_pkg::xlen_t cause_code;

	// Widen the internal code to mcause. Misalignment carries a private code.
	always_comb begin
		case (exc_cause_i)
			hf_pkg::EXC_INSTR_MISALIGN: cause_code = '0;
			default:                    cause_code = hf_pkg::xlen_t'(exc_cause_i);
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mepc_o   <= '0;
			mcause_o <= '0;
			mtval_o  <= '0;
		end else if (exc_i) begin // Held until the next report.
			mepc_o   <= exc_pc_i;
			mcause_o <= cause_code;
			mtval_o  <= exc_tval_i;
		end
	end

endmodule

//--- source/hf_pkg.sv
// Shared types: data and register address types, exception causes, FSM states, history entry.

`include "hf_settings.svh"

package hf_pkg;

	typedef logic [`HF_XLEN-1:0] xlen_t;
	typedef logic [$clog2(`HF_NREGS)-1:0] reg_addr_t;

	// Exception codes as carried on the writeback bus.
	// The nonzero codes follow mcause, except that instruction misalignment
	// (mcause 0) needs its own code because zero means no exception here.
	typedef enum logic [3:0] {
		EXC_NONE           = 4'd0,
		EXC_ILLEGAL        = 4'd2,
		EXC_LOAD_FAULT     = 4'd5,
		EXC_STORE_FAULT    = 4'd7,
		EXC_INSTR_MISALIGN = 4'd15 // Reported as mcause 0.
	} exc_cause_e;

	typedef enum logic [1:0] {
		HF_RUN,     // Normal dispatch, completion and retirement.
		HF_RECOVER, // Walking back and restoring old register values.
		HF_REPORT   // One cycle presenting the exception fields.
	} hf_state_e;

	// One history file entry, written at dispatch and completed at writeback.
	typedef struct packed {
		logic       done;
		exc_cause_e cause;
		xlen_t      miss_addr;
		xlen_t      pc;
		reg_addr_t  rd;
		xlen_t      old_value; // Destination value before this instruction.
	} hf_entry_t;

endpackage

//--- source/hf_settings.svh
// Global sizing macros for data width, register count and history depth.

`ifndef HF_SETTINGS_SVH
`define HF_SETTINGS_SVH

// ----------------------------------------
// Datapath
// ----------------------------------------

// Width of PCs, register data and the exception fields.
`define HF_XLEN 32

// Number of architectural integer registers.
`define HF_NREGS 32

// ----------------------------------------
// History file
// ----------------------------------------

`define HF_DEPTH 16 // Must be a power of two so the pointers wrap on their own.

`endif

//--- source/history_file.sv
// History file queue with in-order retirement, pipeline kill and rollback recovery FSM.

`timescale 1ns/1ns

`include "hf_settings.svh"

module history_file (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                dispatch_valid_i,
	input  hf_pkg::xlen_t       dispatch_pc_i,
	input  hf_pkg::reg_addr_t   dispatch_rd_i,
	input  hf_pkg::xlen_t       old_value_i,
	input  logic                wb_valid_i,
	input  hf_pkg::xlen_t       wb_pc_i,
	input  hf_pkg::exc_cause_e  wb_exc_i,
	input  hf_pkg::xlen_t       wb_miss_addr_i,
	rf_write_if.requester       rec_wr,
	output logic                stall_o,
	output logic                kill_o,
	output hf_pkg::xlen_t       kill_pc_o,
	output logic                exc_o,
	output hf_pkg::xlen_t       exc_pc_o,
	output hf_pkg::exc_cause_e  exc_cause_o,
	output hf_pkg::xlen_t       exc_tval_o
);

	localparam int PTR_W = $clog2(`HF_DEPTH);
	localparam int CNT_W = $clog2(`HF_DEPTH + 1);

	hf_pkg::hf_entry_t hf_q [`HF_DEPTH];

	hf_pkg::hf_state_e state;
	logic [PTR_W-1:0] head;    // Oldest entry.
	logic [PTR_W-1:0] tail;    // Next free slot.
	logic [CNT_W-1:0] count;
	logic [PTR_W-1:0] rec_ptr; // Entry being restored during recovery.

	logic [`HF_DEPTH-1:0] entry_valid;
	logic                 wb_hit;
	logic [PTR_W-1:0]     wb_idx;
	logic                 push;
	logic                 mark;
	logic                 head_done;
	logic                 retire;

	// ----------------------------------------
	// Occupancy and completion lookup
	// ----------------------------------------

	// An entry is live when its distance from the head is below the count.
	always_comb begin
		logic [PTR_W-1:0] offs;
		for (int i = 0; i < `HF_DEPTH; i++) begin
			offs = PTR_W'(i) - head;
			entry_valid[i] = CNT_W'(offs) < count;
		end
	end

	// Completions are matched by PC against live entries that are still pending.
	always_comb begin
		wb_hit = 1'b0;
		wb_idx = '0;
		for (int i = 0; i < `HF_DEPTH; i++) begin
			if (entry_valid[i] && !hf_q[i].done && hf_q[i].pc == wb_pc_i) begin
				wb_hit = 1'b1;
				wb_idx = PTR_W'(i);
			end
		end
	end

	assign head_done = (state == hf_pkg::HF_RUN) && (count != '0) && hf_q[head].done;
	assign retire    = head_done && (hf_q[head].cause == hf_pkg::EXC_NONE);
	assign kill_o    = head_done && (hf_q[head].cause != hf_pkg::EXC_NONE);
	assign kill_pc_o = hf_q[head].pc;

	assign stall_o = (count == CNT_W'(`HF_DEPTH)) || (state != hf_pkg::HF_RUN) || kill_o;
	assign push    = dispatch_valid_i && !stall_o;
	assign mark    = wb_valid_i && wb_hit && (state == hf_pkg::HF_RUN);

	// ----------------------------------------
	// Entry storage
	// ----------------------------------------

	always_ff @(posedge clk_i) begin
		if (push) begin
			hf_q[tail] <= '{
				done:      1'b0,
				cause:     hf_pkg::EXC_NONE,
				miss_addr: '0,
				pc:        dispatch_pc_i,
				rd:        dispatch_rd_i,
				old_value: old_value_i
			};
		end
		if (mark) begin
			hf_q[wb_idx].done      <= 1'b1;
			hf_q[wb_idx].cause     <= wb_exc_i;
			hf_q[wb_idx].miss_addr <= wb_miss_addr_i;
		end
	end

	// ----------------------------------------
	// Pointers and recovery FSM
	// ----------------------------------------

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state   <= hf_pkg::HF_RUN;
			head    <= '0;
			tail    <= '0;
			count   <= '0;
			rec_ptr <= '0;
		end else begin
			case (state)
				hf_pkg::HF_RUN: begin
					if (push) tail <= tail + 1'b1;
					if (retire) head <= head + 1'b1;
					count <= count + CNT_W'(push) - CNT_W'(retire);
					if (kill_o) begin // Dispatch is stalled here, so tail is stable.
						state   <= hf_pkg::HF_RECOVER;
						rec_ptr <= tail - 1'b1;
					end
				end
				hf_pkg::HF_RECOVER: begin
					if (rec_wr.grant) begin
						if (rec_ptr == head) state <= hf_pkg::HF_REPORT;
						else rec_ptr <= rec_ptr - 1'b1;
					end
				end
				default: begin
					// Report done. Everything from the fault onward is discarded.
					state <= hf_pkg::HF_RUN;
					head  <= tail;
					count <= '0;
				end
			endcase
		end
	end

	// Restoring writes, newest entry first.
	assign rec_wr.req  = (state == hf_pkg::HF_RECOVER);
	assign rec_wr.addr = hf_q[rec_ptr].rd;
	assign rec_wr.data = hf_q[rec_ptr].old_value;

	// The faulting entry still sits at the head while the report is out.
	assign exc_o       = (state == hf_pkg::HF_REPORT);
	assign exc_pc_o    = hf_q[head].pc;
	assign exc_cause_o = hf_q[head].cause;
	assign exc_tval_o  = hf_q[head].miss_addr;

endmodule

//--- source/precise_exc_top.sv
// Top level of the precise exception block: history file, write arbiter, register file, capture.

`timescale 1ns/1ns

module precise_exc_top (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              dispatch_valid_i,
	input  hf_pkg::xlen_t     dispatch_pc_i,
	input  hf_pkg::reg_addr_t dispatch_rd_i,
	input  logic              wb_valid_i,
	input  hf_pkg::xlen_t     wb_pc_i,
	input  hf_pkg::reg_addr_t wb_rd_i,
	input  hf_pkg::xlen_t     wb_data_i,
	input  logic [3:0]        wb_exc_i,
	input  hf_pkg::xlen_t     wb_miss_addr_i,
	input  hf_pkg::reg_addr_t dbg_raddr_i,
	output hf_pkg::xlen_t     dbg_rdata_o,
	output logic              stall_o,
	output logic              kill_o,
	output hf_pkg::xlen_t     kill_pc_o,
	output logic              exc_o,
	output hf_pkg::xlen_t     mepc_o,
	output hf_pkg::xlen_t     mcause_o,
	output hf_pkg::xlen_t     mtval_o
);

	rf_write_if wb_wr ();
	rf_write_if rec_wr ();

	logic               rf_we;
	hf_pkg::reg_addr_t  rf_waddr;
	hf_pkg::xlen_t      rf_wdata;
	hf_pkg::xlen_t      old_value;
	hf_pkg::xlen_t      exc_pc;
	hf_pkg::exc_cause_e exc_cause;
	hf_pkg::xlen_t      exc_tval;

	// Writeback results go straight to the register file through the arbiter.
	assign wb_wr.req  = wb_valid_i;
	assign wb_wr.addr = wb_rd_i;
	assign wb_wr.data = wb_data_i;

	history_file i_history_file (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.dispatch_valid_i (dispatch_valid_i),
		.dispatch_pc_i    (dispatch_pc_i),
		.dispatch_rd_i    (dispatch_rd_i),
		.old_value_i      (old_value),
		.wb_valid_i       (wb_valid_i),
		.wb_pc_i          (wb_pc_i),
		.wb_exc_i         (hf_pkg::exc_cause_e'(wb_exc_i)),
		.wb_miss_addr_i   (wb_miss_addr_i),
		.rec_wr           (rec_wr.requester),
		.stall_o          (stall_o),
		.kill_o           (kill_o),
		.kill_pc_o        (kill_pc_o),
		.exc_o            (exc_o),
		.exc_pc_o         (exc_pc),
		.exc_cause_o      (exc_cause),
		.exc_tval_o       (exc_tval)
	);

	rf_write_arbiter i_rf_write_arbiter (
		.rec_wr  (rec_wr.arbiter),
		.wb_wr   (wb_wr.arbiter),
		.we_o    (rf_we),
		.waddr_o (rf_waddr),
		.wdata_o (rf_wdata)
	);

	// Port A supplies the old destination value at dispatch, port B is for debug.
	regfile i_regfile (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.we_i      (rf_we),
		.waddr_i   (rf_waddr),
		.wdata_i   (rf_wdata),
		.raddr_a_i (dispatch_rd_i),
		.rdata_a_o (old_value),
		.raddr_b_i (dbg_raddr_i),
		.rdata_b_o (dbg_rdata_o)
	);

	exc_capture i_exc_capture (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.exc_i       (exc_o),
		.exc_pc_i    (exc_pc),
		.exc_cause_i (exc_cause),
		.exc_tval_i  (exc_tval),
		.mepc_o      (mepc_o),
		.mcause_o    (mcause_o),
		.mtval_o     (mtval_o)
	);

endmodule

//--- source/regfile.sv
// Integer register file with one write port and two combinational read ports.

`timescale 1ns/1ns

`include "hf_settings.svh"

module regfile (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              we_i,
	input  hf_pkg::reg_addr_t waddr_i,
	input  hf_pkg::xlen_t     wdata_i,
	input  hf_pkg::reg_addr_t raddr_a_i,
	output hf_pkg::xlen_t     rdata_a_o,
	input  hf_pkg::reg_addr_t raddr_b_i,
	output hf_pkg::xlen_t     rdata_b_o
);

	hf_pkg::xlen_t regs [`HF_NREGS];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `HF_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != '0) begin // Writes to x0 are ignored.
			regs[waddr_i] <= wdata_i;
		end
	end

	// x0 reads as zero regardless of what the array holds.
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- source/rf_write_arbiter.sv
// Fixed-priority arbiter for the register file write port, recovery over writeback.

`timescale 1ns/1ns

module rf_write_arbiter (
	rf_write_if.arbiter       rec_wr,
	rf_write_if.arbiter       wb_wr,
	output logic              we_o,
	output hf_pkg::reg_addr_t waddr_o,
	output hf_pkg::xlen_t     wdata_o
);

	// ----------------------------------------
	// Grants
	// ----------------------------------------

	// Recovery always wins. A writeback that loses is simply dropped,
	// since it can only come from an instruction that was killed.
	always_comb begin
		rec_wr.grant = rec_wr.req;
		wb_wr.grant  = wb_wr.req && !rec_wr.req;
	end

	// ----------------------------------------
	// Write port mux
	// ----------------------------------------

	always_comb begin
		we_o = rec_wr.grant || wb_wr.grant;
		if (rec_wr.grant) begin
			waddr_o = rec_wr.addr;
			wdata_o = rec_wr.data;
		end else begin
			waddr_o = wb_wr.addr; // Also the idle value; we_o is low then.
			wdata_o = wb_wr.data;
		end
	end

endmodule

//--- source/rf_write_if.sv
// Interface for one register file write requester, with requester and arbiter modports.

`timescale 1ns/1ns

interface rf_write_if;

	logic              req;
	logic              grant; // Same-cycle grant from the arbiter.
	hf_pkg::reg_addr_t addr;
	hf_pkg::xlen_t     data;

	modport requester (
		output req, addr, data,
		input  grant
	);

	modport arbiter (
		input  req, addr, data,
		output grant
	);

endinterface

//--- tb/hf_cases.txt
// Columns (hex): op a b c d e. Op 1 dispatch pc rd count, 2 writeback pc rd data cause miss,
// 3 register rd value, 4 exception kill_pc mepc mcause mtval, 5 stall value, 6 wait unstall, 0 end.
// In-order completion without exceptions.
1 00000100 01 1 0 0
1 00000104 02 1 0 0
2 00000100 01 11111111 0 0
2 00000104 02 22222222 0 0
3 01 11111111 0 0 0
3 02 22222222 0 0 0
5 0 0 0 0 0
// Out-of-order completion without exceptions.
1 00000200 03 1 0 0
1 00000204 04 1 0 0
2 00000204 04 44444444 0 0
2 00000200 03 33333333 0 0
3 03 33333333 0 0 0
3 04 44444444 0 0 0
// Load fault on the oldest instruction after the younger ones completed.
1 00000300 01 1 0 0
1 00000304 02 1 0 0
1 00000308 06 1 0 0
2 00000304 02 aaaaaaaa 0 0
2 00000308 06 bbbbbbbb 0 0
2 00000300 01 cccccccc 5 80000010
4 00000300 00000300 00000005 80000010 0
3 01 11111111 0 0 0
3 02 22222222 0 0 0
3 06 00000000 0 0 0
// Illegal instruction on a younger entry while the oldest is still pending.
1 00000400 03 1 0 0
1 00000404 04 1 0 0
1 00000408 05 1 0 0
2 00000404 04 dddddddd 2 00000013
2 00000408 05 eeeeeeee 0 0
2 00000400 03 ffffffff 0 0
4 00000404 00000404 00000002 00000013 0
3 03 ffffffff 0 0 0
3 04 44444444 0 0 0
3 05 00000000 0 0 0
// Full queue raises stall until the head retires.
1 00000500 07 10 0 0
5 1 0 0 0 0
2 00000500 07 77777777 0 0
6 0 0 0 0 0
5 0 0 0 0 0
0 0 0 0 0 0

//--- tb/precise_exc_properties.sv
// Concurrent assertions on the history file kill, report, stall and recovery write signals.

`timescale 1ns/1ns

module precise_exc_properties (
	input logic clk_i,
	input logic rst_n_i,
	input logic stall_i,
	input logic kill_i,
	input logic exc_i,
	input logic rec_req_i
);

	int   assert_failures = 0; // Total of failed assertions in this instance.
	logic in_recovery;         // High from a kill until its exception report.

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			in_recovery <= 1'b0;
		end else if (kill_i) begin
			in_recovery <= 1'b1;
		end else if (exc_i) begin
			in_recovery <= 1'b0;
		end
	end

	// ----------------------------------------
	// Pulse widths and stall
	// ----------------------------------------

	kill_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) kill_i |=> !kill_i)
		else begin
			assert_failures++;
			$error("kill_o stayed high for more than one cycle");
		end

	exc_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i) exc_i |=> !exc_i)
		else begin
			assert_failures++;
			$error("exc_o stayed high for more than one cycle");
		end

	// The pipeline must be held while it is being killed or the trap is reported.
	stall_on_event: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(kill_i || exc_i) |-> stall_i)
		else begin
			assert_failures++;
			$error("stall_o was low during a kill or an exception report");
		end

	rec_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rec_req_i |-> in_recovery)
		else begin
			assert_failures++;
			$error("recovery write requested outside a kill to report window");
		end

endmodule

//--- tb/tb_precise_exc.sv
// Testbench for the precise exception top level: case file stimulus, result checks, timeout.

`timescale 1ns/1ns

`include "hf_settings.svh"

module tb_precise_exc;

	parameter int SEED = 98182;

	localparam int RA_W          = $clog2(`HF_NREGS);
	localparam int FIELDS        = 6; // Words per case line.
	localparam int MAX_OPS       = 64;
	localparam int RST_CYCLES    = 16;
	localparam int CYCLES_PER_OP = 40;

	logic               clk_i;
	logic               rst_n_i;
	logic               dispatch_valid_i;
	logic [`HF_XLEN-1:0] dispatch_pc_i;
	logic [RA_W-1:0]    dispatch_rd_i;
	logic               wb_valid_i;
	logic [`HF_XLEN-1:0] wb_pc_i;
	logic [RA_W-1:0]    wb_rd_i;
	logic [`HF_XLEN-1:0] wb_data_i;
	logic [3:0]         wb_exc_i;
	logic [`HF_XLEN-1:0] wb_miss_addr_i;
	logic [RA_W-1:0]    dbg_raddr_i;
	logic [`HF_XLEN-1:0] dbg_rdata_o;
	logic               stall_o;
	logic               kill_o;
	logic [`HF_XLEN-1:0] kill_pc_o;
	logic               exc_o;
	logic [`HF_XLEN-1:0] mepc_o;
	logic [`HF_XLEN-1:0] mcause_o;
	logic [`HF_XLEN-1:0] mtval_o;

	logic [`HF_XLEN-1:0] case_mem [MAX_OPS*FIELDS];
	int                 errors;
	int                 cycles;
	int                 cycle_limit;
	logic               kill_expected; // Set while an exception case waits for its kill.

	precise_exc_top i_dut (
		.clk_i            (clk_i),
		.rst_n_i          (rst_n_i),
		.dispatch_valid_i (dispatch_valid_i),
		.dispatch_pc_i    (dispatch_pc_i),
		.dispatch_rd_i    (dispatch_rd_i),
		.wb_valid_i       (wb_valid_i),
		.wb_pc_i          (wb_pc_i),
		.wb_rd_i          (wb_rd_i),
		.wb_data_i        (wb_data_i),
		.wb_exc_i         (wb_exc_i),
		.wb_miss_addr_i   (wb_miss_addr_i),
		.dbg_raddr_i      (dbg_raddr_i),
		.dbg_rdata_o      (dbg_rdata_o),
		.stall_o          (stall_o),
		.kill_o           (kill_o),
		.kill_pc_o        (kill_pc_o),
		.exc_o            (exc_o),
		.mepc_o           (mepc_o),
		.mcause_o         (mcause_o),
		.mtval_o          (mtval_o)
	);

	bind history_file precise_exc_properties i_props (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.stall_i   (stall_o),
		.kill_i    (kill_o),
		.exc_i     (exc_o),
		.rec_req_i (rec_wr.req)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// ----------------------------------------
	// Helpers
	// ----------------------------------------

	task automatic check_value(input string name, input logic [`HF_XLEN-1:0] expected,
		input logic [`HF_XLEN-1:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic drive_idle();
		dispatch_valid_i = 1'b0;
		dispatch_pc_i    = '0;
		dispatch_rd_i    = '0;
		wb_valid_i       = 1'b0;
		wb_pc_i          = '0;
		wb_rd_i          = '0;
		wb_data_i        = '0;
		wb_exc_i         = '0;
		wb_miss_addr_i   = '0;
		dbg_raddr_i      = '0;
	endtask

	task automatic next_cycle();
		@(posedge clk_i);
		#1;
	endtask

	task automatic idle_gap();
		int gap;
		gap = $urandom % 3;
		repeat (gap) next_cycle();
	endtask

	// Polls at 1 ns after each edge, where stall_o has settled for the whole cycle.
	task automatic wait_stall_clear();
		int waited;
		waited = 0;
		while (stall_o && waited < CYCLES_PER_OP) begin
			next_cycle();
			waited++;
		end
		if (stall_o) begin
			errors++;
			$display("stall_o stayed high for %0d cycles at %0t ns", waited, $time);
		end
	endtask

	task automatic dispatch_burst(input logic [`HF_XLEN-1:0] pc, input logic [RA_W-1:0] rd,
		input int n);
		for (int k = 0; k < n; k++) begin
			wait_stall_clear();
			dispatch_valid_i = 1'b1;
			dispatch_pc_i    = pc + `HF_XLEN'(4 * k); // Consecutive instructions.
			dispatch_rd_i    = rd;
			next_cycle();
		end
		dispatch_valid_i = 1'b0;
	endtask

	task automatic writeback(input logic [`HF_XLEN-1:0] pc, input logic [RA_W-1:0] rd,
		input logic [`HF_XLEN-1:0] data, input logic [3:0] cause,
		input logic [`HF_XLEN-1:0] miss);
		wb_valid_i     = 1'b1;
		wb_pc_i        = pc;
		wb_rd_i        = rd;
		wb_data_i      = data;
		wb_exc_i       = cause;
		wb_miss_addr_i = miss;
		next_cycle();
		wb_valid_i = 1'b0;
	endtask

	task automatic check_register(input logic [RA_W-1:0] rd, input logic [`HF_XLEN-1:0] value);
		dbg_raddr_i = rd;
		@(negedge clk_i);
		check_value($sformatf("dbg_rdata_o (x%0d)", rd), value, dbg_rdata_o);
		next_cycle();
	endtask

	task automatic check_stall(input logic value);
		@(negedge clk_i);
		check_value("stall_o", `HF_XLEN'(value), `HF_XLEN'(stall_o));
		next_cycle();
	endtask

	// Kill and report lengths vary with the queue, so both are polled.
	task automatic expect_exception(input logic [`HF_XLEN-1:0] kill_pc,
		input logic [`HF_XLEN-1:0] mepc, input logic [`HF_XLEN-1:0] mcause,
		input logic [`HF_XLEN-1:0] mtval);
		kill_expected = 1'b1;
		@(negedge clk_i);
		while (!kill_o) @(negedge clk_i);
		check_value("kill_pc_o", kill_pc, kill_pc_o);
		@(negedge clk_i);
		kill_expected = 1'b0;
		while (!exc_o) @(negedge clk_i);
		@(negedge clk_i); // The trap registers load on the report edge.
		check_value("mepc_o", mepc, mepc_o);
		check_value("mcause_o", mcause, mcause_o);
		check_value("mtval_o", mtval, mtval_o);
		next_cycle();
	endtask

	task automatic check_reset_state();
		@(negedge clk_i);
		check_value("kill_o", '0, `HF_XLEN'(kill_o));
		check_value("exc_o", '0, `HF_XLEN'(exc_o));
		check_value("stall_o", '0, `HF_XLEN'(stall_o));
		next_cycle();
		for (int r = 0; r < `HF_NREGS; r++) begin
			check_register(RA_W'(r), '0);
		end
	endtask

	task automatic run_op(input int base);
		logic [`HF_XLEN-1:0] f [FIELDS];
		for (int i = 0; i < FIELDS; i++) begin
			f[i] = case_mem[base + i];
		end
		if (f[0] == 1 || f[0] == 2) idle_gap(); // No gap may hide a kill pulse.
		case (f[0])
			1: dispatch_burst(f[1], RA_W'(f[2]), f[3]);
			2: writeback(f[1], RA_W'(f[2]), f[3], f[4][3:0], f[5]);
			3: check_register(RA_W'(f[1]), f[2]);
			4: expect_exception(f[1], f[2], f[3], f[4]);
			5: check_stall(f[1][0]);
			6: wait_stall_clear();
			default: begin
				errors++;
				$display("Unknown operation code %h on case line %0d", f[0], base / FIELDS);
			end
		endcase
	endtask

	// ----------------------------------------
	// Monitors and main sequence
	// ----------------------------------------

	always @(negedge clk_i) begin
		if (rst_n_i && kill_o && !kill_expected) begin
			errors++;
			$display("Unexpected kill at %0t ns for PC %h", $time, kill_pc_o);
		end
	end

	initial begin
		cycles = 0;
		@(posedge clk_i);
		while (cycles < cycle_limit) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: the cases did not finish within %0d cycles", cycle_limit);
		$display("test failed");
		$finish;
	end

	initial begin
		int n_ops;
		n_ops         = 0;
		errors        = 0;
		kill_expected = 1'b0;
		rst_n_i       = 1'b0;
		void'($urandom(SEED));
		drive_idle();
		$readmemh("tb/hf_cases.txt", case_mem);
		while (n_ops < MAX_OPS && case_mem[n_ops * FIELDS] != '0) n_ops++;
		// One extra slot covers the register sweep after reset.
		cycle_limit = CYCLES_PER_OP * (n_ops + 1) + RST_CYCLES;
		if (n_ops == 0) begin
			errors++;
			$display("No operations were read from the case file");
		end
		repeat (RST_CYCLES) @(posedge clk_i);
		#1;
		rst_n_i = 1'b1;
		check_reset_state();
		for (int i = 0; i < n_ops; i++) begin
			run_op(i * FIELDS);
		end
		$display("Check errors: %0d, assertion failures: %0d", errors,
			i_dut.i_history_file.i_props.assert_failures);
		if (errors == 0 && i_dut.i_history_file.i_props.assert_failures == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+source
source/hf_pkg.sv
source/rf_write_if.sv
source/history_file.sv
source/rf_write_arbiter.sv
source/regfile.sv
source/exc_capture.sv
source/precise_exc_top.sv
tb/precise_exc_properties.sv
tb/tb_precise_exc.sv
